// ==== build.f ====
+incdir+.
rv_pkg.sv
rv_ctrl_if.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the core testbench with verilator, run it, judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary -f build.f --top-module tb_rv_core \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_rv_core > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no verdict found in sim.log"; exit 1; }
echo "simulation passed"

// ==== rv_core.sv ====
`default_nettype none

`include "rv_params.svh"

module rv_core (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire                        instr_valid_i,
    input  wire [`XLEN-1:0]            instr_i,
    output logic                       retire_valid_o,
    output logic [`XLEN-1:0]           retire_pc_o,
    output logic                       retire_we_o,
    output logic [`REG_ADDR_WIDTH-1:0] retire_rd_o,
    output logic [`XLEN-1:0]           retire_wdata_o,
    output logic [`XLEN-1:0]           retire_next_pc_o
);

    logic [`XLEN-1:0]           pc;
    logic [`XLEN-1:0]           instr_dec;  // zero word decodes to a nop
    logic                       is_jalr;
    logic [`REG_ADDR_WIDTH-1:0] rs1_addr, rs2_addr;
    logic [`XLEN-1:0]           rs1_data, rs2_data;
    logic [`XLEN-1:0]           alu_res, next_pc, link, lsu_rdata;
    logic                       rf_we;
    logic [`XLEN-1:0]           wb_data;

    rv_ctrl_if ctrl ();

    assign instr_dec = instr_valid_i ? instr_i : '0;
    assign is_jalr   = (instr_dec[6:0] == rv_pkg::OPC_JALR);
    assign rf_we     = instr_valid_i && ctrl.reg_w;

    rv_decoder u_decoder (
        .instr_i    (instr_dec),
        .ctrl       (ctrl.dec),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr)
    );

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_addr_i  (ctrl.rd_addr),
        .rd_data_i  (wb_data)
    );

    rv_execute u_execute (
        .ctrl       (ctrl.exe),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .is_jalr_i  (is_jalr),
        .alu_res_o  (alu_res),
        .next_pc_o  (next_pc),
        .link_o     (link)
    );

    rv_lsu u_lsu (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ctrl    (ctrl.lsu),
        .valid_i (instr_valid_i),
        .addr_i  (alu_res),   // rs1 + imm
        .wdata_i (rs2_data),
        .rdata_o (lsu_rdata)
    );

    // write-back select, jumps are the only branches that write rd
    always_comb begin
        if (ctrl.is_load_store && !ctrl.mem_w)
            wb_data = lsu_rdata;
        else if (ctrl.is_branch && ctrl.reg_w)
            wb_data = link;
        else
            wb_data = alu_res;
    end

    // pc and retire control
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc             <= '0;
            retire_valid_o <= 1'b0;
            retire_we_o    <= 1'b0;
        end else begin
            retire_valid_o <= instr_valid_i;  // one cycle pulse per instruction
            retire_we_o    <= rf_we;
            if (instr_valid_i) pc <= next_pc;
        end
    end

    // retire record payload, held between instructions
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            retire_pc_o      <= pc;
            retire_rd_o      <= ctrl.rd_addr;
            retire_wdata_o   <= wb_data;
            retire_next_pc_o <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== rv_ctrl_if.sv ====
`default_nettype none

`include "rv_params.svh"

interface rv_ctrl_if;

    rv_pkg::alu_op_e          alu_op;
    rv_pkg::lis_op_e          lis_op;
    rv_pkg::br_op_e           br_op;
    rv_pkg::data_origin_e     data_origin;
    logic                     is_branch;     // jal, jalr and conditional branches
    logic                     is_load_store;
    logic                     mem_w;         // store
    logic                     reg_w;         // rd gets written
    logic [`REG_ADDR_WIDTH-1:0] rd_addr;
    logic [`XLEN-1:0]         imm_val;       // already sign extended

    modport dec (output alu_op, lis_op, br_op, data_origin, is_branch,
                        is_load_store, mem_w, reg_w, rd_addr, imm_val);

    modport exe (input alu_op, br_op, data_origin, is_branch, imm_val);

    modport lsu (input lis_op, is_load_store, mem_w);

endinterface

`default_nettype wire

// ==== rv_decoder.sv ====
`default_nettype none

`include "rv_params.svh"

module rv_decoder (
    input  wire [`XLEN-1:0]            instr_i,
    rv_ctrl_if.dec                     ctrl,
    output logic [`REG_ADDR_WIDTH-1:0] rs1_addr_o,
    output logic [`REG_ADDR_WIDTH-1:0] rs2_addr_o
);

    rv_pkg::opcode_e            opcode;
    logic [2:0]                 funct3;
    logic                       funct7_b5; // sub / sra select
    logic [`REG_ADDR_WIDTH-1:0] rd, rs1, rs2;
    logic [`XLEN-1:0]           imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_pkg::alu_op_e            arith_op;  // shared by op and op_imm

    assign opcode    = rv_pkg::opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];
    assign rd        = instr_i[11:7];
    assign rs1       = instr_i[19:15];
    assign rs2       = instr_i[24:20];

    // immediates sign extended from bit 31
    assign imm_i = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{(`XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{(`XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    // funct3 picks the alu op
    // bit 30 means sub only for register-register ops
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == rv_pkg::OPC_OP && funct7_b5) ? rv_pkg::ALU_SUB
                                                                        : rv_pkg::ALU_ADD;
            3'b001:  arith_op = rv_pkg::ALU_SLL;
            3'b010:  arith_op = rv_pkg::ALU_SLT;
            3'b011:  arith_op = rv_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_pkg::ALU_XOR;
            3'b101:  arith_op = funct7_b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  arith_op = rv_pkg::ALU_OR;
            default: arith_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        // defaults give a nop with no writes of any kind
        ctrl.alu_op        = rv_pkg::ALU_ADD;
        ctrl.lis_op        = rv_pkg::LIS_LW;
        ctrl.br_op         = rv_pkg::BR_EQ;
        ctrl.data_origin   = rv_pkg::REGS;
        ctrl.is_branch     = 1'b0;
        ctrl.is_load_store = 1'b0;
        ctrl.mem_w         = 1'b0;
        ctrl.reg_w         = 1'b0;
        ctrl.rd_addr       = '0;
        ctrl.imm_val       = '0;
        rs1_addr_o         = '0;
        rs2_addr_o         = '0;

        case (opcode)
            rv_pkg::OPC_LUI: begin  // x0 + imm
                ctrl.data_origin = rv_pkg::IMM_RS1;
                ctrl.imm_val     = imm_u;
                ctrl.reg_w       = 1'b1;
                ctrl.rd_addr     = rd;
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl.data_origin = rv_pkg::IMM_PC;
                ctrl.imm_val     = imm_u;
                ctrl.reg_w       = 1'b1;
                ctrl.rd_addr     = rd;
            end
            rv_pkg::OPC_JAL: begin  // alu forms pc + imm and rd gets the link
                ctrl.is_branch   = 1'b1;
                ctrl.data_origin = rv_pkg::IMM_PC;
                ctrl.imm_val     = imm_j;
                ctrl.reg_w       = 1'b1;
                ctrl.rd_addr     = rd;
            end
            rv_pkg::OPC_JALR: begin  // alu forms rs1 + imm
                ctrl.is_branch   = 1'b1;
                ctrl.data_origin = rv_pkg::IMM_RS1;
                ctrl.imm_val     = imm_i;
                ctrl.reg_w       = 1'b1;
                ctrl.rd_addr     = rd;
                rs1_addr_o       = rs1;
            end
            rv_pkg::OPC_BRANCH: begin  // alu compares and execute builds the target
                ctrl.is_branch = 1'b1;
                ctrl.imm_val   = imm_b;
                ctrl.alu_op    = rv_pkg::ALU_SUB;
                rs1_addr_o     = rs1;
                rs2_addr_o     = rs2;
                case (funct3)
                    3'b001: ctrl.br_op = rv_pkg::BR_NE;
                    3'b100: begin
                        ctrl.alu_op = rv_pkg::ALU_SLT;
                        ctrl.br_op  = rv_pkg::BR_LT;
                    end
                    3'b101: begin
                        ctrl.alu_op = rv_pkg::ALU_SLT;
                        ctrl.br_op  = rv_pkg::BR_GE;
                    end
                    3'b110: begin
                        ctrl.alu_op = rv_pkg::ALU_SLTU;
                        ctrl.br_op  = rv_pkg::BR_LT;
                    end
                    3'b111: begin
                        ctrl.alu_op = rv_pkg::ALU_SLTU;
                        ctrl.br_op  = rv_pkg::BR_GE;
                    end
                    default: ctrl.br_op = rv_pkg::BR_EQ; // beq
                endcase
            end
            rv_pkg::OPC_LOAD: begin  // address = rs1 + imm
                ctrl.is_load_store = 1'b1;
                ctrl.data_origin   = rv_pkg::IMM_RS1;
                ctrl.imm_val       = imm_i;
                ctrl.reg_w         = 1'b1;
                ctrl.rd_addr       = rd;
                rs1_addr_o         = rs1;
                case (funct3)
                    3'b000:  ctrl.lis_op = rv_pkg::LIS_LB;
                    3'b001:  ctrl.lis_op = rv_pkg::LIS_LH;
                    3'b100:  ctrl.lis_op = rv_pkg::LIS_LBU;
                    3'b101:  ctrl.lis_op = rv_pkg::LIS_LHU;
                    default: ctrl.lis_op = rv_pkg::LIS_LW;
                endcase
            end
            rv_pkg::OPC_STORE: begin
                ctrl.is_load_store = 1'b1;
                ctrl.mem_w         = 1'b1;
                ctrl.data_origin   = rv_pkg::IMM_RS1;
                ctrl.imm_val       = imm_s;
                rs1_addr_o         = rs1;
                rs2_addr_o         = rs2;  // store data
                case (funct3)
                    3'b000:  ctrl.lis_op = rv_pkg::LIS_SB;
                    3'b001:  ctrl.lis_op = rv_pkg::LIS_SH;
                    default: ctrl.lis_op = rv_pkg::LIS_SW;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin  // shamt sits in imm[4:0]
                ctrl.alu_op      = arith_op;
                ctrl.data_origin = rv_pkg::IMM_RS1;
                ctrl.imm_val     = imm_i;
                ctrl.reg_w       = 1'b1;
                ctrl.rd_addr     = rd;
                rs1_addr_o       = rs1;
            end
            rv_pkg::OPC_OP: begin
                ctrl.alu_op  = arith_op;
                ctrl.reg_w   = 1'b1;
                ctrl.rd_addr = rd;
                rs1_addr_o   = rs1;
                rs2_addr_o   = rs2;
            end
            default: ;  // fence, system and unknown words retire as nop
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
`default_nettype none

`include "rv_params.svh"

module rv_execute (
    rv_ctrl_if.exe           ctrl,
    input  wire [`XLEN-1:0]  pc_i,
    input  wire [`XLEN-1:0]  rs1_data_i,
    input  wire [`XLEN-1:0]  rs2_data_i,
    input  wire              is_jalr_i,
    output logic [`XLEN-1:0] alu_res_o,
    output logic [`XLEN-1:0] next_pc_o,
    output logic [`XLEN-1:0] link_o
);

    logic [`XLEN-1:0] op_a, op_b;
    logic [4:0]       shamt;
    logic             taken;   // conditional branch outcome
    logic [`XLEN-1:0] pc_plus4;

    // operand select
    always_comb begin
        case (ctrl.data_origin)
            rv_pkg::IMM_RS1: begin
                op_a = rs1_data_i;
                op_b = ctrl.imm_val;
            end
            rv_pkg::IMM_PC: begin
                op_a = pc_i;
                op_b = ctrl.imm_val;
            end
            default: begin  // regs
                op_a = rs1_data_i;
                op_b = rs2_data_i;
            end
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::ALU_SUB:  alu_res_o = op_a - op_b;
            rv_pkg::ALU_SLL:  alu_res_o = op_a << shamt;
            rv_pkg::ALU_SLT:  alu_res_o = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_res_o = {{(`XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::ALU_XOR:  alu_res_o = op_a ^ op_b;
            rv_pkg::ALU_SRL:  alu_res_o = op_a >> shamt;
            rv_pkg::ALU_SRA:  alu_res_o = $unsigned($signed(op_a) >>> shamt); // sign fill
            rv_pkg::ALU_OR:   alu_res_o = op_a | op_b;
            rv_pkg::ALU_AND:  alu_res_o = op_a & op_b;
            default:          alu_res_o = op_a + op_b;
        endcase
    end

    // eq/ne look at the sub result, lt/ge at the compare bit
    always_comb begin
        case (ctrl.br_op)
            rv_pkg::BR_NE: taken = (alu_res_o != '0);
            rv_pkg::BR_LT: taken = alu_res_o[0];
            rv_pkg::BR_GE: taken = !alu_res_o[0];
            default:       taken = (alu_res_o == '0);
        endcase
    end

    assign pc_plus4 = pc_i + `XLEN'd4;
    assign link_o   = pc_plus4;

    always_comb begin
        if (!ctrl.is_branch)
            next_pc_o = pc_plus4;
        else if (is_jalr_i)
            next_pc_o = {alu_res_o[`XLEN-1:1], 1'b0};          // jalr clears bit 0
        else if (ctrl.data_origin == rv_pkg::IMM_PC)
            next_pc_o = alu_res_o;                              // jal, pc + imm from alu
        else
            next_pc_o = taken ? pc_i + ctrl.imm_val : pc_plus4; // conditional
    end

endmodule

`default_nettype wire

// ==== rv_lsu.sv ====
`default_nettype none

`include "rv_params.svh"

module rv_lsu (
    input  wire              clk_i,
    input  wire              rst_n_i,
    rv_ctrl_if.lsu           ctrl,
    input  wire              valid_i,
    input  wire [`XLEN-1:0]  addr_i,
    input  wire [`XLEN-1:0]  wdata_i,
    output logic [`XLEN-1:0] rdata_o
);

    localparam int DEPTH = 2 ** `DMEM_ADDR_WIDTH;

    logic [`XLEN-1:0]            mem [0:DEPTH-1];
    logic [`DMEM_ADDR_WIDTH-1:0] waddr;   // word index
    logic [1:0]                  boff;    // byte offset in word
    logic [3:0]                  be;      // byte enables
    logic [`XLEN-1:0]            wdata_al; // store data replicated into lanes
    logic [`XLEN-1:0]            rword;
    logic [7:0]                  rbyte;
    logic [15:0]                 rhalf;

    assign waddr = addr_i[`DMEM_ADDR_WIDTH+1:2];
    assign boff  = addr_i[1:0];

    always_comb begin
        case (ctrl.lis_op)
            rv_pkg::LIS_SB: begin
                be       = 4'b0001 << boff;
                wdata_al = {4{wdata_i[7:0]}};
            end
            rv_pkg::LIS_SH: begin
                be       = 4'b0011 << {boff[1], 1'b0}; // halfword aligned
                wdata_al = {2{wdata_i[15:0]}};
            end
            default: begin
                be       = 4'b1111;
                wdata_al = wdata_i;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) mem[i] <= '0;
        end else if (valid_i && ctrl.is_load_store && ctrl.mem_w) begin
            for (int b = 0; b < 4; b++)
                if (be[b]) mem[waddr][8*b +: 8] <= wdata_al[8*b +: 8];
        end
    end

    // combinational read, sees a store from an earlier cycle
    assign rword = mem[waddr];
    assign rbyte = rword[8*boff +: 8];
    assign rhalf = rword[16*boff[1] +: 16];

    always_comb begin
        case (ctrl.lis_op)
            rv_pkg::LIS_LB:  rdata_o = {{(`XLEN-8){rbyte[7]}}, rbyte};
            rv_pkg::LIS_LBU: rdata_o = {{(`XLEN-8){1'b0}}, rbyte};
            rv_pkg::LIS_LH:  rdata_o = {{(`XLEN-16){rhalf[15]}}, rhalf};
            rv_pkg::LIS_LHU: rdata_o = {{(`XLEN-16){1'b0}}, rhalf};
            default:         rdata_o = rword;
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path and instruction word width
`define XLEN 32

// register index, 32 architectural registers
`define REG_ADDR_WIDTH 5

// data memory depth as a word address width, 8 gives 256 words
`define DMEM_ADDR_WIDTH 8

`endif

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // rv32i major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_FENCE  = 7'b0001111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,  // also used for beq/bne
        ALU_SLL,
        ALU_SLT,  // signed compare, blt/bge
        ALU_SLTU, // unsigned compare, bltu/bgeu
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // load/store kind, sign handling lives in the load kinds
    typedef enum logic [2:0] {
        LIS_LB, LIS_LH, LIS_LW, LIS_LBU, LIS_LHU,
        LIS_SB, LIS_SH, LIS_SW
    } lis_op_e;

    // lt/ge take signedness from the alu op
    typedef enum logic [1:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE
    } br_op_e;

    // where the alu operands come from
    typedef enum logic [1:0] {
        REGS,    // a = rs1, b = rs2
        IMM_RS1, // a = rs1, b = imm
        IMM_PC   // a = pc,  b = imm
    } data_origin_e;

endpackage

`default_nettype wire

// ==== rv_regfile.sv ====
`default_nettype none

`include "rv_params.svh"

module rv_regfile (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  rs1_addr_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  rs2_addr_i,
    output logic [`XLEN-1:0]           rs1_data_o,
    output logic [`XLEN-1:0]           rs2_data_o,
    input  wire                        we_i,
    input  wire [`REG_ADDR_WIDTH-1:0]  rd_addr_i,
    input  wire [`XLEN-1:0]            rd_data_i
);

    logic [`XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (we_i && rd_addr_i != '0) begin  // x0 writes dropped
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // asynchronous read, x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

// ==== tb_input.txt ====
# columns, all hex: instr pc we rd wdata next_pc, then a note
# one line per accepted instruction, wdata and rd only checked when we is 1
00500093 00000000 1 01 00000005 00000004  addi x1, x0, 5
ffd00113 00000004 1 02 fffffffd 00000008  addi x2, x0, -3
002081b3 00000008 1 03 00000002 0000000c  add x3, x1, x2
40208233 0000000c 1 04 00000008 00000010  sub x4, x1, x2
001122b3 00000010 1 05 00000001 00000014  slt x5, x2, x1
00113333 00000014 1 06 00000000 00000018  sltu x6, x2, x1
40115393 00000018 1 07 fffffffe 0000001c  srai x7, x2, 1
01c15413 0000001c 1 08 0000000f 00000020  srli x8, x2, 28
00708013 00000020 1 00 0000000c 00000024  addi x0, x1, 7
001004b3 00000024 1 09 00000005 00000028  add x9, x0, x1
00409513 00000028 1 0a 00000050 0000002c  slli x10, x1, 4
123455b7 0000002c 1 0b 12345000 00000030  lui x11, 0x12345
00001617 00000030 1 0c 00001030 00000034  auipc x12, 1
04b02023 00000034 0 00 00000000 00000038  sw x11, 0x40(x0)
042000a3 00000038 0 00 00000000 0000003c  sb x2, 0x41(x0)
04a01323 0000003c 0 00 00000000 00000040  sh x10, 0x46(x0)
04002703 00000040 1 0e 1234fd00 00000044  lw x14, 0x40(x0)
04100783 00000044 1 0f fffffffd 00000048  lb x15, 0x41(x0)
04001883 00000048 1 11 fffffd00 0000004c  lh x17, 0x40(x0)
04605903 0000004c 1 12 00000050 00000050  lhu x18, 0x46(x0)
00108463 00000050 0 00 00000000 00000058  beq x1, x1, +8 taken
00208463 00000058 0 00 00000000 0000005c  beq x1, x2, +8 not taken
00209463 0000005c 0 00 00000000 00000064  bne x1, x2, +8 taken
00109463 00000064 0 00 00000000 00000068  bne x1, x1, +8 not taken
00114463 00000068 0 00 00000000 00000070  blt x2, x1, +8 taken
0020c463 00000070 0 00 00000000 00000074  blt x1, x2, +8 not taken
0020e463 00000074 0 00 00000000 0000007c  bltu x1, x2, +8 taken
00116463 0000007c 0 00 00000000 00000080  bltu x2, x1, +8 not taken
0020d463 00000080 0 00 00000000 00000088  bge x1, x2, +8 taken
00115463 00000088 0 00 00000000 0000008c  bge x2, x1, +8 not taken
00117463 0000008c 0 00 00000000 00000094  bgeu x2, x1, +8 taken
0020f463 00000094 0 00 00000000 00000098  bgeu x1, x2, +8 not taken
01000a6f 00000098 1 14 0000009c 000000a8  jal x20, +16
02150ae7 000000a8 1 15 000000ac 00000070  jalr x21, 0x21(x10), bit 0 cleared
0ff0000f 00000070 0 00 00000000 00000074  fence

// ==== tb_rv_core.sv ====
`default_nettype none

`include "rv_params.svh"

module tb_rv_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 4;  // ns
    localparam int MAX_IDLE   = 2;  // idle cycles between two instructions

    logic                       clk;
    logic                       rst_n;
    logic                       instr_valid;
    logic [`XLEN-1:0]           instr;
    logic                       retire_valid;
    logic [`XLEN-1:0]           retire_pc;
    logic                       retire_we;
    logic [`REG_ADDR_WIDTH-1:0] retire_rd;
    logic [`XLEN-1:0]           retire_wdata;
    logic [`XLEN-1:0]           retire_next_pc;

    // one entry per vector line of tb_input.txt
    logic [`XLEN-1:0]           vec_instr   [$];
    logic [`XLEN-1:0]           vec_pc      [$];
    logic                       vec_we      [$];
    logic [`REG_ADDR_WIDTH-1:0] vec_rd      [$];
    logic [`XLEN-1:0]           vec_wdata   [$];
    logic [`XLEN-1:0]           vec_next_pc [$];

    bit vectors_loaded = 1'b0;
    int last_idx       = -1;  // vector the DUT takes at the next edge or -1 when idle
    int cur_idx        = -1;  // vector under check

    rv_core DUT (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .instr_valid_i    (instr_valid),
        .instr_i          (instr),
        .retire_valid_o   (retire_valid),
        .retire_pc_o      (retire_pc),
        .retire_we_o      (retire_we),
        .retire_rd_o      (retire_rd),
        .retire_wdata_o   (retire_wdata),
        .retire_next_pc_o (retire_next_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: vector %0d %s is %h, expected %h",
                     $time, cur_idx, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_rd(input string name, input logic [`REG_ADDR_WIDTH-1:0] got,
                            input logic [`REG_ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: vector %0d %s is x%0d, expected x%0d",
                     $time, cur_idx, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: vector %0d %s is %b, expected %b",
                     $time, cur_idx, name, got, exp);
            stop_run();
        end
    endtask

    // lines starting with # are skipped
    // text after the six fields is ignored
    task automatic load_vectors();
        int                         fd;
        int                         n;
        string                      line;
        logic [`XLEN-1:0]           w, pc, wd, npc;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       we;
        fd = $fopen("tb_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb_input.txt in the project root");
            stop_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h", w, pc, we, rd, wd, npc);
            if (n == 6) begin
                vec_instr.push_back(w);
                vec_pc.push_back(pc);
                vec_we.push_back(we);
                vec_rd.push_back(rd);
                vec_wdata.push_back(wd);
                vec_next_pc.push_back(npc);
            end else if (n > 0) begin
                $display("tb_input.txt has a line with too few fields: %s", line);
                stop_run();
            end
        end
        $fclose(fd);
        if (vec_instr.size() == 0) begin
            $display("tb_input.txt holds no vectors");
            stop_run();
        end
    endtask

    // rd and wdata only mean something when the register file is written
    task automatic check_retire(input int idx);
        cur_idx = idx;
        check_flag("retire_valid", retire_valid, 1'b1);
        check_word("retire_pc", retire_pc, vec_pc[idx]);
        check_flag("retire_we", retire_we, vec_we[idx]);
        if (vec_we[idx]) begin
            check_rd("retire_rd", retire_rd, vec_rd[idx]);
            check_word("retire_wdata", retire_wdata, vec_wdata[idx]);
        end
        check_word("retire_next_pc", retire_next_pc, vec_next_pc[idx]);
    endtask

    // drive at the edge and check what the DUT took at that edge
    task automatic drive_cycle(input logic valid, input logic [`XLEN-1:0] word,
                               input int idx);
        @(posedge clk);
        instr_valid <= valid;
        instr       <= word;
        @(negedge clk);  // retire registers settled
        if (last_idx >= 0) begin
            check_retire(last_idx);
        end else begin
            cur_idx = -1;
            check_flag("retire_valid while idle", retire_valid, 1'b0);
            check_flag("retire_we while idle", retire_we, 1'b0);
        end
        last_idx = valid ? idx : -1;
    endtask

    initial begin
        int seed;
        int idle;
        instr_valid = 1'b0;
        instr       = '0;
        rst_n       = 1'b0;
        seed = $urandom(99);  // seed for the idle gap lengths
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < vec_instr.size(); i++) begin
            idle = $urandom_range(MAX_IDLE, 0);
            repeat (idle) drive_cycle(1'b0, vec_instr[i], -1);  // word stays on the bus
            drive_cycle(1'b1, vec_instr[i], i);
        end
        drive_cycle(1'b0, '0, -1);  // last retire
        drive_cycle(1'b0, '0, -1);  // pulse has to drop again
        $display("TEST PASSED");
        $finish;
    end

    // at most 3 cycles per vector plus reset and flush
    initial begin
        int limit_ns;
        wait (vectors_loaded);
        limit_ns = vec_instr.size() * 5 * CLK_PERIOD + 200;
        #(limit_ns);
        $display("core timed out, the test did not finish within %0d ns", limit_ns);
        stop_run();
    end

endmodule

`default_nettype wire
